/* design/cache_pkg.sv */
// Cache geometry, Wishbone burst codes, FSM state codes and address and line types for wb_dcache
package cache_pkg;

        // --------------------------------------------------
        // Geometry
        // --------------------------------------------------
        localparam int LINE_BYTES = 16;
        localparam int LINE_WORDS = LINE_BYTES / 4;
        localparam int NUM_LINES  = 16;
        localparam int WORD_SEL_W = $clog2(LINE_WORDS);
        localparam int INDEX_W    = $clog2(NUM_LINES);
        localparam int TAG_W      = 32 - INDEX_W - WORD_SEL_W - 2;

        // Wishbone cycle type identifiers
        localparam logic [2:0] CTI_BURST = 3'b010;
        localparam logic [2:0] CTI_EOB   = 3'b111;

        // Controller states
        localparam logic [1:0] ST_IDLE  = 2'd0;
        localparam logic [1:0] ST_EVICT = 2'd1;
        localparam logic [1:0] ST_FILL  = 2'd2;

        // Flat bus address, or split into cache fields
        typedef union packed {
                logic [31:0] flat;
                struct packed {
                        logic [TAG_W-1:0]      tag;
                        logic [INDEX_W-1:0]    index;
                        logic [WORD_SEL_W-1:0] word_sel;
                        logic [1:0]            byte_off;
                } f;
        } addr_u;

        // One cache line, word 0 at the lowest address
        typedef logic [LINE_WORDS-1:0][31:0] line_t;

endpackage

/* design/wb_master_if.sv */
// Wishbone master bundle between a line engine and the cache controller's bus mux
`timescale 1ns/1ns
interface wb_master_if;

        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat_w;
        logic [3:0]  sel;
        logic [2:0]  cti;
        logic        ack;
        logic [31:0] dat_r;

        // Engine side
        modport master (output cyc, stb, we, adr, dat_w, sel, cti,
                        input  ack, dat_r);

        // Controller side, routes one engine to the bus
        modport ctrl (input  cyc, stb, we, adr, dat_w, sel, cti,
                      output ack, dat_r);

endinterface

/* design/line_fill.sv */
// Line fill engine, burst-reads one cache line from memory into a line buffer on i_start
`timescale 1ns/1ns
module line_fill import cache_pkg::*;
(
        input  logic               i_clk,
        input  logic               i_reset,
        input  logic               i_start,
        input  logic [31:0]        i_base,
        wb_master_if.master        bus,
        output logic               o_done,
        output line_t              o_line
);

logic                  active;
logic [WORD_SEL_W-1:0] beat;
logic                  last_beat;
addr_u                 base_q;
addr_u                 beat_adr;
line_t                 buf_q;

assign last_beat = (beat == WORD_SEL_W'(LINE_WORDS - 1));

// Word address of the current beat
always_comb
begin
        beat_adr            = base_q;
        beat_adr.f.word_sel = beat;
end

assign bus.cyc   = active;
assign bus.stb   = active;
assign bus.we    = 1'b0;
assign bus.adr   = beat_adr.flat;
assign bus.dat_w = '0;
assign bus.sel   = 4'hf;
assign bus.cti   = last_beat ? CTI_EOB : CTI_BURST;

assign o_line = buf_q;

// --------------------------------------------------
// Beat sequencing
// --------------------------------------------------
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                active <= 1'b0;
                beat   <= '0;
                o_done <= 1'b0;
        end
        else
        begin
                o_done <= active && bus.ack && last_beat;
                if (i_start)
                begin
                        active <= 1'b1;
                        beat   <= '0;
                end
                else if (active && bus.ack)
                begin
                        beat <= beat + 1'b1;
                        if (last_beat)
                        begin
                                active <= 1'b0;
                        end
                end
        end
end

// Base latch and line buffer capture
always_ff @(posedge i_clk)
begin
        if (i_start)
        begin
                base_q.flat <= i_base;
        end
        if (active && bus.ack)
        begin
                buf_q[beat] <= bus.dat_r;
        end
end

// A waiting beat keeps its request steady
a_fill_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        bus.stb && !bus.ack |=> bus.stb && $stable(bus.adr) && $stable(bus.cti));

endmodule

/* design/line_evict.sv */
// Line evict engine, burst-writes one dirty victim line back to memory on i_start
`timescale 1ns/1ns
module line_evict import cache_pkg::*;
(
        input  logic               i_clk,
        input  logic               i_reset,
        input  logic               i_start,
        input  logic [31:0]        i_base,
        input  line_t              i_line,
        wb_master_if.master        bus,
        output logic               o_done
);

logic                  active;
logic [WORD_SEL_W-1:0] beat;
logic                  last_beat;
addr_u                 base_q;
addr_u                 beat_adr;
line_t                 line_q;

assign last_beat = (beat == WORD_SEL_W'(LINE_WORDS - 1));

always_comb
begin
        beat_adr            = base_q;
        beat_adr.f.word_sel = beat;
end

assign bus.cyc   = active;
assign bus.stb   = active;
assign bus.we    = 1'b1;
assign bus.adr   = beat_adr.flat;
assign bus.dat_w = line_q[beat];
assign bus.sel   = 4'hf;
assign bus.cti   = last_beat ? CTI_EOB : CTI_BURST;

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                active <= 1'b0;
                beat   <= '0;
                o_done <= 1'b0;
        end
        else
        begin
                o_done <= active && bus.ack && last_beat;
                if (i_start)
                begin
                        active <= 1'b1;
                        beat   <= '0;
                end
                else if (active && bus.ack)
                begin
                        beat <= beat + 1'b1;
                        if (last_beat)
                        begin
                                active <= 1'b0;
                        end
                end
        end
end

// Victim snapshot, store may change under us afterwards
always_ff @(posedge i_clk)
begin
        if (i_start)
        begin
                base_q.flat <= i_base;
                line_q      <= i_line;
        end
end

a_evict_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        bus.stb && !bus.ack |=> bus.stb && $stable(bus.adr) && $stable(bus.cti));

endmodule

/* design/cache_store.sv */
// Direct-mapped line store with tag, valid and dirty bits, written by line fills and word writes
`timescale 1ns/1ns
module cache_store import cache_pkg::*;
(
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  logic [INDEX_W-1:0]    i_index,
        input  logic                  i_fill_en,
        input  logic [TAG_W-1:0]      i_fill_tag,
        input  line_t                 i_fill_line,
        input  logic                  i_word_en,
        input  logic [WORD_SEL_W-1:0] i_word_sel,
        input  logic [31:0]           i_word_data,
        input  logic [3:0]            i_word_ben,
        output logic [TAG_W-1:0]      o_tag,
        output logic                  o_valid,
        output logic                  o_dirty,
        output line_t                 o_line
);

logic [TAG_W-1:0]     tag_mem  [NUM_LINES];
line_t                data_mem [NUM_LINES];
logic [NUM_LINES-1:0] valid_q;
logic [NUM_LINES-1:0] dirty_q;

// Combinational read of the addressed line
assign o_tag   = tag_mem[i_index];
assign o_valid = valid_q[i_index];
assign o_dirty = dirty_q[i_index];
assign o_line  = data_mem[i_index];

// Valid and dirty flags
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                valid_q <= '0;
                dirty_q <= '0;
        end
        else if (i_fill_en)
        begin
                valid_q[i_index] <= 1'b1;
                dirty_q[i_index] <= 1'b0;
        end
        else if (i_word_en)
        begin
                dirty_q[i_index] <= 1'b1;
        end
end

// Tag and data arrays
always_ff @(posedge i_clk)
begin
        if (i_fill_en)
        begin
                tag_mem[i_index]  <= i_fill_tag;
                data_mem[i_index] <= i_fill_line;
        end
        else if (i_word_en)
        begin
                for (int b = 0; b < 4; b++)
                begin
                        if (i_word_ben[b])
                        begin
                                data_mem[i_index][i_word_sel][8*b +: 8] <= i_word_data[8*b +: 8];
                        end
                end
        end
end

a_no_fill_and_write: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_fill_en && i_word_en));

endmodule

/* design/cache_ctrl.sv */
// Cache controller, hit detection, miss FSM, store update and routing of both line engines
`timescale 1ns/1ns
module cache_ctrl import cache_pkg::*;
(
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  logic                  i_rd,
        input  logic                  i_wr,
        input  logic [31:0]           i_addr,
        input  logic [31:0]           i_wdata,
        input  logic [3:0]            i_ben,
        output logic [31:0]           o_rdata,
        output logic                  o_ack,
        output logic                  o_idle,
        output logic [INDEX_W-1:0]    o_index,
        input  logic [TAG_W-1:0]      i_tag,
        input  logic                  i_valid,
        input  logic                  i_dirty,
        input  line_t                 i_line,
        output logic                  o_fill_en,
        output logic [TAG_W-1:0]      o_fill_tag,
        output line_t                 o_fill_line,
        output logic                  o_word_en,
        output logic [WORD_SEL_W-1:0] o_word_sel,
        output logic [31:0]           o_word_data,
        output logic [3:0]            o_word_ben,
        output logic                  o_fill_start,
        output logic [31:0]           o_fill_base,
        input  logic                  i_fill_done,
        input  line_t                 i_fill_line,
        output logic                  o_evict_start,
        output logic [31:0]           o_evict_base,
        output line_t                 o_evict_line,
        input  logic                  i_evict_done,
        wb_master_if.ctrl             fill_bus,
        wb_master_if.ctrl             evict_bus,
        output logic                  o_wb_cyc,
        output logic                  o_wb_stb,
        output logic                  o_wb_we,
        output logic [31:0]           o_wb_adr,
        output logic [31:0]           o_wb_dat,
        output logic [3:0]            o_wb_sel,
        output logic [2:0]            o_wb_cti,
        input  logic                  i_wb_ack,
        input  logic [31:0]           i_wb_dat
);

logic [1:0] state;
logic       fill_start_q;
logic       write_q;
logic       req;
logic       hit;
logic       miss;
addr_u      req_adr;
addr_u      fill_adr;
addr_u      evict_adr;

// --------------------------------------------------
// Request decode and hit check
// --------------------------------------------------
assign req_adr.flat = i_addr;
assign req          = i_rd || i_wr;
assign hit          = i_valid && (i_tag == req_adr.f.tag);
assign miss         = (state == ST_IDLE) && req && !hit;

assign o_index = req_adr.f.index;
assign o_ack   = (state == ST_IDLE) && req && hit;
assign o_rdata = i_line[req_adr.f.word_sel];
assign o_idle  = (state == ST_IDLE);

// Write hit merges into the store at this edge
assign o_word_en   = o_ack && i_wr;
assign o_word_sel  = req_adr.f.word_sel;
assign o_word_data = i_wdata;
assign o_word_ben  = i_ben;

// Line bases for the new line and the victim
always_comb
begin
        fill_adr            = req_adr;
        fill_adr.f.word_sel = '0;
        fill_adr.f.byte_off = '0;
        evict_adr           = fill_adr;
        evict_adr.f.tag     = i_tag;
end

assign o_evict_start = miss && i_valid && i_dirty;
assign o_evict_base  = evict_adr.flat;
assign o_evict_line  = i_line;
assign o_fill_start  = (miss && !(i_valid && i_dirty)) || fill_start_q;
assign o_fill_base   = fill_adr.flat;

assign o_fill_en   = write_q;
assign o_fill_tag  = req_adr.f.tag;
assign o_fill_line = i_fill_line;

// --------------------------------------------------
// Miss FSM
// --------------------------------------------------
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                state        <= ST_IDLE;
                fill_start_q <= 1'b0;
                write_q      <= 1'b0;
        end
        else
        begin
                fill_start_q <= 1'b0;
                write_q      <= 1'b0;
                case (state)
                ST_IDLE:
                begin
                        if (miss)
                        begin
                                state <= (i_valid && i_dirty) ? ST_EVICT : ST_FILL;
                        end
                end
                ST_EVICT:
                begin
                        if (i_evict_done)
                        begin
                                state        <= ST_FILL;
                                fill_start_q <= 1'b1;
                        end
                end
                ST_FILL:
                begin
                        if (i_fill_done)
                        begin
                                write_q <= 1'b1;
                        end
                        // Store written this cycle, request hits next
                        if (write_q)
                        begin
                                state <= ST_IDLE;
                        end
                end
                default:
                begin
                        state <= ST_IDLE;
                end
                endcase
        end
end

// --------------------------------------------------
// Bus mux, the evict engine owns the bus while its cyc is up
// --------------------------------------------------
assign o_wb_cyc = evict_bus.cyc ? evict_bus.cyc   : fill_bus.cyc;
assign o_wb_stb = evict_bus.cyc ? evict_bus.stb   : fill_bus.stb;
assign o_wb_we  = evict_bus.cyc ? evict_bus.we    : fill_bus.we;
assign o_wb_adr = evict_bus.cyc ? evict_bus.adr   : fill_bus.adr;
assign o_wb_dat = evict_bus.cyc ? evict_bus.dat_w : fill_bus.dat_w;
assign o_wb_sel = evict_bus.cyc ? evict_bus.sel   : fill_bus.sel;
assign o_wb_cti = evict_bus.cyc ? evict_bus.cti   : fill_bus.cti;

assign evict_bus.ack   = i_wb_ack && evict_bus.cyc;
assign fill_bus.ack    = i_wb_ack && fill_bus.cyc && !evict_bus.cyc;
assign evict_bus.dat_r = i_wb_dat;
assign fill_bus.dat_r  = i_wb_dat;

a_one_engine: assert property (@(posedge i_clk) disable iff (i_reset)
        !(fill_bus.cyc && evict_bus.cyc));

endmodule

/* design/wb_dcache.sv */
// Top level of the write-back data cache, processor port in and Wishbone master port out
`timescale 1ns/1ns
module wb_dcache import cache_pkg::*;
(
        input  logic        i_clk,
        input  logic        i_reset,
        input  logic        i_rd,
        input  logic        i_wr,
        input  logic [31:0] i_addr,
        input  logic [31:0] i_wdata,
        input  logic [3:0]  i_ben,
        output logic [31:0] o_rdata,
        output logic        o_ack,
        output logic        o_idle,
        output logic        o_wb_cyc,
        output logic        o_wb_stb,
        output logic        o_wb_we,
        output logic [31:0] o_wb_adr,
        output logic [31:0] o_wb_dat,
        output logic [3:0]  o_wb_sel,
        output logic [2:0]  o_wb_cti,
        input  logic        i_wb_ack,
        input  logic [31:0] i_wb_dat
);

// Store side
logic [INDEX_W-1:0]    index;
logic [TAG_W-1:0]      tag;
logic                  valid;
logic                  dirty;
line_t                 line;
logic                  fill_en;
logic [TAG_W-1:0]      fill_tag;
line_t                 store_fill_line;
logic                  word_en;
logic [WORD_SEL_W-1:0] word_sel;
logic [31:0]           word_data;
logic [3:0]            word_ben;

// Engine control
logic                  fill_start;
logic [31:0]           fill_base;
logic                  fill_done;
line_t                 fill_line;
logic                  evict_start;
logic [31:0]           evict_base;
line_t                 evict_line;
logic                  evict_done;

wb_master_if fill_bus ();
wb_master_if evict_bus ();

cache_ctrl u_ctrl (
        .i_clk, .i_reset, .i_rd, .i_wr, .i_addr, .i_wdata, .i_ben,
        .o_rdata, .o_ack, .o_idle,
        .o_index      (index),
        .i_tag        (tag),
        .i_valid      (valid),
        .i_dirty      (dirty),
        .i_line       (line),
        .o_fill_en    (fill_en),
        .o_fill_tag   (fill_tag),
        .o_fill_line  (store_fill_line),
        .o_word_en    (word_en),
        .o_word_sel   (word_sel),
        .o_word_data  (word_data),
        .o_word_ben   (word_ben),
        .o_fill_start (fill_start),
        .o_fill_base  (fill_base),
        .i_fill_done  (fill_done),
        .i_fill_line  (fill_line),
        .o_evict_start(evict_start),
        .o_evict_base (evict_base),
        .o_evict_line (evict_line),
        .i_evict_done (evict_done),
        .fill_bus     (fill_bus.ctrl),
        .evict_bus    (evict_bus.ctrl),
        .o_wb_cyc, .o_wb_stb, .o_wb_we, .o_wb_adr, .o_wb_dat, .o_wb_sel, .o_wb_cti,
        .i_wb_ack, .i_wb_dat
);

cache_store u_store (
        .i_clk, .i_reset,
        .i_index    (index),
        .i_fill_en  (fill_en),
        .i_fill_tag (fill_tag),
        .i_fill_line(store_fill_line),
        .i_word_en  (word_en),
        .i_word_sel (word_sel),
        .i_word_data(word_data),
        .i_word_ben (word_ben),
        .o_tag      (tag),
        .o_valid    (valid),
        .o_dirty    (dirty),
        .o_line     (line)
);

line_fill u_fill (
        .i_clk, .i_reset,
        .i_start(fill_start),
        .i_base (fill_base),
        .bus    (fill_bus.master),
        .o_done (fill_done),
        .o_line (fill_line)
);

line_evict u_evict (
        .i_clk, .i_reset,
        .i_start(evict_start),
        .i_base (evict_base),
        .i_line (evict_line),
        .bus    (evict_bus.master),
        .o_done (evict_done)
);

endmodule

/* tb/wb_dcache_tb.sv */
// Self-checking testbench for wb_dcache with random processor traffic against a Wishbone memory model
`timescale 1ns/1ns
module wb_dcache_tb import cache_pkg::*;
();

localparam int NUM_OPS        = 300;
localparam int TIMEOUT_CYCLES = NUM_OPS * (2 * LINE_WORDS * 4 + 4);

logic        i_clk;
logic        i_reset;
logic        i_rd;
logic        i_wr;
logic [31:0] i_addr;
logic [31:0] i_wdata;
logic [3:0]  i_ben;
logic [31:0] o_rdata;
logic        o_ack;
logic        o_idle;
logic        o_wb_cyc;
logic        o_wb_stb;
logic        o_wb_we;
logic [31:0] o_wb_adr;
logic [31:0] o_wb_dat;
logic [3:0]  o_wb_sel;
logic [2:0]  o_wb_cti;
logic        i_wb_ack;
logic [31:0] i_wb_dat;

int               seed = 84;
int               cycle_count = 0;
int               wait_left;
int               fill_count = 0;
int               evict_count = 0;
logic [31:0]      bus_mem [bit [31:0]];
logic [31:0]      ref_mem [bit [31:0]];
bit               line_dirty [bit [31:0]];
logic [TAG_W-1:0] tag_pool [4];

// Burst monitor state
int          beat_idx;
logic        beat_held;
logic [31:0] burst_base;
logic        burst_we;
logic [31:0] prev_adr;
logic [31:0] prev_dat;
logic [2:0]  prev_cti;
logic [3:0]  prev_sel;
logic        prev_we;

// Bus request as seen at the last falling edge
logic        s_stb = 1'b0;
logic        s_we;
logic [31:0] s_adr;
logic [31:0] s_dat;
logic [3:0]  s_sel;

wb_dcache dut (.*);

always #20 i_clk = ~i_clk;

// --------------------------------------------------
// Memory contents and reference model
// --------------------------------------------------
function automatic logic [31:0] fill_pattern(input logic [31:0] adr);
        return (adr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
endfunction

function automatic logic [31:0] line_base(input logic [31:0] adr);
        return adr & ~32'(LINE_BYTES - 1);
endfunction

function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                            input logic [3:0] ben);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++)
        begin
                if (ben[b])
                begin
                        res[8*b +: 8] = data[8*b +: 8];
                end
        end
        return res;
endfunction

// Processor view of a word
function automatic logic [31:0] ref_word(input logic [31:0] adr);
        bit [31:0] key;
        key = {adr[31:2], 2'b00};
        return ref_mem.exists(key) ? ref_mem[key] : fill_pattern(key);
endfunction

// What the bus memory holds right now
function automatic logic [31:0] mem_word(input logic [31:0] adr);
        bit [31:0] key;
        key = {adr[31:2], 2'b00};
        return bus_mem.exists(key) ? bus_mem[key] : fill_pattern(key);
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected)
        begin
                $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
                $display("Test failed");
                $fatal(1, "check failed");
        end
endtask

// One processor access held until o_ack
task automatic run_access(input logic is_wr, input logic [31:0] adr, input logic [31:0] data,
                          input logic [3:0] ben, input logic expect_hit);
        @(posedge i_clk);
        i_rd    <= !is_wr;
        i_wr    <= is_wr;
        i_addr  <= adr;
        i_wdata <= data;
        i_ben   <= ben;
        @(negedge i_clk);
        if (expect_hit)
        begin
                check_value($sformatf("repeat line ack at %h", adr), 1, o_ack);
                check_value($sformatf("repeat line bus idle at %h", adr), 0, o_wb_cyc);
        end
        while (!o_ack)
        begin
                @(negedge i_clk);
                // Miss in progress after the cycle that detected it
                if (!o_ack)
                begin
                        check_value($sformatf("idle low during miss at %h", adr), 0, o_idle);
                end
        end
        if (is_wr)
        begin
                ref_mem[{adr[31:2], 2'b00}] = merge_bytes(ref_word(adr), data, ben);
                line_dirty[line_base(adr)]  = 1'b1;
        end
        else
        begin
                check_value($sformatf("read data at %h", adr), ref_word(adr), o_rdata);
        end
        @(posedge i_clk);
        i_rd <= 1'b0;
        i_wr <= 1'b0;
endtask

// --------------------------------------------------
// Bus monitor for burst shape and write-back data
// --------------------------------------------------
always @(negedge i_clk)
begin
        s_stb = o_wb_stb;
        s_we  = o_wb_we;
        s_adr = o_wb_adr;
        s_dat = o_wb_dat;
        s_sel = o_wb_sel;
        if (i_reset)
        begin
                beat_idx  = 0;
                beat_held = 1'b0;
        end
        else if (o_wb_stb)
        begin
                check_value("cyc during beat", 1, o_wb_cyc);
                if (beat_held)
                begin
                        check_value("held beat address", prev_adr, o_wb_adr);
                        check_value("held beat cti", prev_cti, o_wb_cti);
                        check_value("held beat we", prev_we, o_wb_we);
                        check_value("held beat data", prev_dat, o_wb_dat);
                        check_value("held beat sel", prev_sel, o_wb_sel);
                end
                else
                begin
                        if (beat_idx == 0)
                        begin
                                burst_base = o_wb_adr;
                                burst_we   = o_wb_we;
                                check_value("burst base alignment", 0,
                                            o_wb_adr & 32'(LINE_BYTES - 1));
                                if (o_wb_we)
                                begin
                                        // Only lines written since their fill go back
                                        check_value($sformatf("victim %h dirty", o_wb_adr), 1,
                                                    line_dirty.exists(o_wb_adr) &&
                                                    line_dirty[o_wb_adr]);
                                        evict_count++;
                                end
                                else
                                begin
                                        fill_count++;
                                end
                                line_dirty[o_wb_adr] = 1'b0;
                        end
                        check_value("beat address", burst_base + 32'(4 * beat_idx), o_wb_adr);
                        check_value("beat cti", (beat_idx == LINE_WORDS - 1) ? CTI_EOB : CTI_BURST,
                                    o_wb_cti);
                        check_value("beat direction", burst_we, o_wb_we);
                        check_value("beat sel", 4'hf, o_wb_sel);
                        if (o_wb_we)
                        begin
                                check_value($sformatf("write-back data at %h", o_wb_adr),
                                            ref_word(o_wb_adr), o_wb_dat);
                        end
                end
                prev_adr = o_wb_adr;
                prev_cti = o_wb_cti;
                prev_we  = o_wb_we;
                prev_dat = o_wb_dat;
                prev_sel = o_wb_sel;
                if (i_wb_ack)
                begin
                        beat_idx  = (beat_idx + 1) % LINE_WORDS;
                        beat_held = 1'b0;
                end
                else
                begin
                        beat_held = 1'b1;
                end
        end
        else
        begin
                check_value("burst length", 0, beat_idx);
                check_value("cyc without stb", 0, o_wb_cyc);
                beat_held = 1'b0;
        end
end

// Memory slave with 0 to 3 wait cycles per beat and a one-cycle ack
always @(posedge i_clk)
begin
        if (i_reset)
        begin
                i_wb_ack <= 1'b0;
                wait_left = $random(seed) & 3;
        end
        else if (i_wb_ack)
        begin
                i_wb_ack <= 1'b0;
                wait_left = $random(seed) & 3;
        end
        else if (s_stb)
        begin
                if (wait_left == 0)
                begin
                        i_wb_ack <= 1'b1;
                        if (s_we)
                        begin
                                bus_mem[{s_adr[31:2], 2'b00}] = merge_bytes(mem_word(s_adr),
                                                                            s_dat, s_sel);
                        end
                        else
                        begin
                                i_wb_dat <= mem_word(s_adr);
                        end
                end
                else
                begin
                        wait_left--;
                end
        end
end

always @(posedge i_clk)
begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
        begin
                $display("Timed out after %0d cycles before all accesses finished", cycle_count);
                $display("Test failed");
                $fatal(1, "timeout");
        end
end

// --------------------------------------------------
// Stimulus
// --------------------------------------------------
initial
begin
        addr_u       a;
        logic [31:0] prev_addr;
        logic        is_wr;
        logic        same_line;
        logic [31:0] data;
        logic [3:0]  ben;
        i_clk    = 1'b0;
        i_reset  = 1'b1;
        i_rd     = 1'b0;
        i_wr     = 1'b0;
        i_addr   = '0;
        i_wdata  = '0;
        i_ben    = '0;
        i_wb_ack = 1'b0;
        i_wb_dat = '0;
        prev_addr = '0;
        // Few tags over few indices, so lines keep conflicting
        tag_pool = '{24'h000010, 24'h000ab3, 24'h7f0002, 24'hc00051};
        repeat (3) @(posedge i_clk);
        i_reset <= 1'b0;
        @(negedge i_clk);
        check_value("ack after reset", 0, o_ack);
        check_value("cyc after reset", 0, o_wb_cyc);
        check_value("stb after reset", 0, o_wb_stb);
        check_value("idle after reset", 1, o_idle);
        for (int n = 0; n < NUM_OPS; n++)
        begin
                a.f.tag      = tag_pool[$random(seed) & 3];
                a.f.index    = INDEX_W'(($random(seed) & 3) * 5);
                a.f.word_sel = WORD_SEL_W'($random(seed));
                a.f.byte_off = 2'b00;
                // Now and then go back to the last line
                if (n > 0 && ($random(seed) & 3) == 0)
                begin
                        a.flat       = prev_addr;
                        a.f.word_sel = WORD_SEL_W'($random(seed));
                end
                same_line = (n > 0) && (line_base(a.flat) == line_base(prev_addr));
                is_wr     = $random(seed) & 1;
                data      = $random(seed);
                ben       = 4'($random(seed));
                run_access(is_wr, a.flat, data, ben, same_line);
                prev_addr = a.flat;
        end
        repeat (2) @(negedge i_clk);
        check_value("idle at end", 1, o_idle);
        check_value("bus quiet at end", 0, o_wb_cyc);
        $display("%0d accesses, %0d line fills, %0d write-backs", NUM_OPS, fill_count,
                 evict_count);
        $display("Test passed");
        $finish;
end

endmodule

/* wb_dcache.f */
design/cache_pkg.sv
design/wb_master_if.sv
design/line_fill.sv
design/line_evict.sv
design/cache_store.sv
design/cache_ctrl.sv
design/wb_dcache.sv
tb/wb_dcache_tb.sv

/* Bender.yml */
package:
  name: wb_dcache

sources:
  - design/cache_pkg.sv
  - design/wb_master_if.sv
  - design/line_fill.sv
  - design/line_evict.sv
  - design/cache_store.sv
  - design/cache_ctrl.sv
  - design/wb_dcache.sv
  - target: test
    files:
      - tb/wb_dcache_tb.sv
